// File: ddr_phy_top.f
+incdir+.
ddr_phy_pkg.sv
ddr_cmd_retime.sv
ddr_dq_lane.sv
ddr_phy_top.sv
tb_ddr_phy_top.sv

// File: tb_ddr_phy_checks.svh
/* DDR PHY testbench checks */

`ifndef TB_DDR_PHY_CHECKS_SVH
`define TB_DDR_PHY_CHECKS_SVH

task automatic stop_on_failure();
    $display("sim failed");
    $fatal(1, "stopped at the first error");
endtask

task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    stop_on_failure();
endtask

task automatic report_mismatch(input string name, input string expected, input string actual);
    $display("Fail %s: expected %s, actual %s", name, expected, actual);
    stop_on_failure();
endtask

// four-state compares, so a floating or unknown pin is a mismatch
task automatic check_cmd(input string name, input ddr_cmd_e expected, input ddr_cmd_e actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

task automatic check_word(input string name, input dq_word_t expected, input dq_word_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
endtask

task automatic check_mask(input string name, input lane_mask_t expected, input lane_mask_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

task automatic check_rank(input string name, input rank_mask_t expected, input rank_mask_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

task automatic check_bank(input string name, input bank_t expected, input bank_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

task automatic check_addr(input string name, input row_addr_t expected, input row_addr_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
endtask

task automatic check_ce(input string name, input eb_ce_t expected, input eb_ce_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

task automatic check_eb_addr(input string name, input eb_addr_t expected, input eb_addr_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
endtask

task automatic check_eb_data(input string name, input eb_data_t expected, input eb_data_t actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%h", expected), $sformatf("%h", actual));
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
        report_mismatch(name, $sformatf("%b", expected), $sformatf("%b", actual));
endtask

`endif

// File: tb_ddr_phy_top.sv
/* DDR PHY front end testbench */

`timescale 1ns/1ps

module tb_ddr_phy_top;

    import ddr_phy_pkg::*;

    `include "tb_ddr_phy_checks.svh"

    localparam int NUM_ROWS = 24;
    localparam int RUN_LIMIT_NS = 100 * (NUM_ROWS + 40);
    // per-row dq enable covering every on/off transition
    localparam logic [NUM_ROWS-1:0] OE_PATTERN = 24'b0011_0101_1100_1011_0010_0110;

    typedef struct packed {
        ddr_cmd_e   cmd;
        rank_mask_t s_n;
        bank_t      ba;
        row_addr_t  a;
        logic       cke;
        lane_mask_t dqm;
        dq_word_t   wr_data;
        logic       dqoe;
        lane_mask_t dqs_high;
        lane_mask_t dqs_low;
        dq_word_t   rd_high;
        dq_word_t   rd_low;
        eb_ce_t     eb_ce;
        logic       eb_oe;
        logic       eb_we;
        eb_addr_t   eb_addr;
        eb_data_t   eb_wdata;
        logic       eb_wen;
        eb_data_t   eb_rdata;
    } stim_row_t;

    stim_row_t  table_rows [NUM_ROWS];
    integer     seed;

    logic       int_drm_clock_buffered;
    logic       system_reset_in;
    ddr_cmd_e   next_cmd;
    rank_mask_t next_s_n;
    bank_t      next_ba;
    row_addr_t  next_a;
    logic       next_cke;
    lane_mask_t next_dqm;
    dq_word_t   next_dq;
    logic       next_dqoe;
    lane_mask_t next_dqs_high;
    lane_mask_t next_dqs_low;
    eb_ce_t     ext_bus_ce;
    logic       ext_bus_oe;
    logic       ext_bus_we;
    eb_addr_t   ext_bus_address;
    eb_data_t   ext_bus_write_data;
    logic       ext_bus_write_data_enable;

    wire dq_word_t   input_dq_high;
    wire dq_word_t   input_dq_low;
    wire             ddr_dram_clk;
    wire             ddr_dram_clk_n;
    wire rank_mask_t ddr_dram_cke;
    wire rank_mask_t ddr_dram_s_n;
    wire             ddr_dram_ras_n;
    wire             ddr_dram_cas_n;
    wire             ddr_dram_we_n;
    wire bank_t      ddr_dram_ba;
    wire row_addr_t  ddr_dram_a;
    wire lane_mask_t ddr_dram_dqm;
    wire dq_word_t   ddr_dram_dq;
    wire lane_mask_t ddr_dram_dqs;
    wire eb_data_t   ext_bus_read_data;
    wire eb_ce_t     eb_ce_n;
    wire             eb_oe_n;
    wire             eb_we_n;
    wire eb_addr_t   eb_address;
    wire eb_data_t   eb_data;

    // model of the DRAM and the external device driving their data pins
    logic     pad_drive_en;
    dq_word_t pad_value;
    logic     eb_drive_en;
    eb_data_t eb_drive_value;

    assign ddr_dram_dq = pad_drive_en ? pad_value : 'z;
    assign eb_data     = eb_drive_en ? eb_drive_value : 'z;

    ddr_phy_top ddr_phy_top_i (.*);

    initial
    begin
        int_drm_clock_buffered = 1'b0;
        forever
            #50 int_drm_clock_buffered = ~int_drm_clock_buffered;
    end

    initial
    begin
        #(RUN_LIMIT_NS);
        report_timeout("the run went past its time limit without finishing");
    end

    function automatic stim_row_t idle_row();
        stim_row_t row;
        row = '0;
        row.cmd = CMD_NOP;
        row.s_n = IDLE_S_N;
        return row;
    endfunction

    // rows outside the table stand for the idle inputs around the run
    function automatic stim_row_t row_at(input int k);
        if (k < 0 || k >= NUM_ROWS)
            return idle_row();
        return table_rows[k];
    endfunction

    task automatic fill_table();
        logic [8*32-1:0] bits;
        stim_row_t       row;
        for (int k = 0; k < NUM_ROWS; k++)
        begin
            for (int w = 0; w < 8; w++)
                bits[w*32 +: 32] = $random(seed);
            row = stim_row_t'(bits[$bits(stim_row_t)-1:0]);
            // walk through every opcode in turn
            row.cmd = ddr_cmd_e'(k[2:0]);
            row.dqoe = OE_PATTERN[k];
            table_rows[k] = row;
        end
    endtask

    task automatic drive_row(input stim_row_t row);
        next_cmd <= row.cmd;
        next_s_n <= row.s_n;
        next_ba <= row.ba;
        next_a <= row.a;
        next_cke <= row.cke;
        next_dqm <= row.dqm;
        next_dq <= row.wr_data;
        next_dqoe <= row.dqoe;
        next_dqs_high <= row.dqs_high;
        next_dqs_low <= row.dqs_low;
        ext_bus_ce <= row.eb_ce;
        ext_bus_oe <= row.eb_oe;
        ext_bus_we <= row.eb_we;
        ext_bus_address <= row.eb_addr;
        ext_bus_write_data <= row.eb_wdata;
        ext_bus_write_data_enable <= row.eb_wen;
        eb_drive_en <= ~row.eb_wen;
        eb_drive_value <= row.eb_rdata;
    endtask

    task automatic check_idle_pins(input string tag);
        check_cmd({tag, " ras/cas/we"}, CMD_NOP,
                  ddr_cmd_e'({ddr_dram_ras_n, ddr_dram_cas_n, ddr_dram_we_n}));
        check_rank({tag, " chip selects"}, IDLE_S_N, ddr_dram_s_n);
        check_bank({tag, " bank"}, '0, ddr_dram_ba);
        check_addr({tag, " address"}, '0, ddr_dram_a);
        check_rank({tag, " cke"}, '0, ddr_dram_cke);
        check_mask({tag, " dqm"}, '0, ddr_dram_dqm);
        check_word({tag, " dq pins"}, 'z, ddr_dram_dq);
        check_mask({tag, " dqs pins"}, 'z, ddr_dram_dqs);
        check_word({tag, " captured high"}, '0, input_dq_high);
        check_word({tag, " captured low"}, '0, input_dq_low);
    endtask

    // command pins lag by two edges, cke/dqm/dq by one and the external bus by none
    task automatic check_high_phase(input int t);
        stim_row_t cmd_row;
        stim_row_t reg_row;
        stim_row_t eb_row;
        string     tag;
        cmd_row = row_at(t - 2);
        reg_row = row_at(t - 1);
        eb_row = row_at(t);
        tag = $sformatf("cycle %0d", t);
        check_cmd({tag, " ras/cas/we"}, cmd_row.cmd,
                  ddr_cmd_e'({ddr_dram_ras_n, ddr_dram_cas_n, ddr_dram_we_n}));
        check_rank({tag, " chip selects"}, cmd_row.s_n, ddr_dram_s_n);
        check_bank({tag, " bank"}, cmd_row.ba, ddr_dram_ba);
        check_addr({tag, " address"}, cmd_row.a, ddr_dram_a);
        check_rank({tag, " cke"}, {NUM_RANKS{reg_row.cke}}, ddr_dram_cke);
        check_mask({tag, " dqm"}, reg_row.dqm, ddr_dram_dqm);
        if (t >= 2 && !cmd_row.dqoe)
            check_word({tag, " captured high"}, cmd_row.rd_high, input_dq_high);
        if (reg_row.dqoe)
        begin
            check_word({tag, " dq write data"}, reg_row.wr_data, ddr_dram_dq);
            check_mask({tag, " dqs high half"}, reg_row.dqs_high, ddr_dram_dqs);
        end
        else
        begin
            check_word({tag, " dq released"}, 'z, ddr_dram_dq);
            check_mask({tag, " dqs released"}, 'z, ddr_dram_dqs);
            pad_value <= reg_row.rd_low;
            pad_drive_en <= 1'b1;
        end
        check_bit({tag, " dram clk"}, 1'b1, ddr_dram_clk);
        check_bit({tag, " dram clk_n"}, 1'b0, ddr_dram_clk_n);
        check_ce({tag, " eb_ce_n"}, ~eb_row.eb_ce, eb_ce_n);
        check_bit({tag, " eb_oe_n"}, ~eb_row.eb_oe, eb_oe_n);
        check_bit({tag, " eb_we_n"}, ~eb_row.eb_we, eb_we_n);
        check_eb_addr({tag, " eb_address"}, eb_row.eb_addr, eb_address);
        if (eb_row.eb_wen)
        begin
            check_eb_data({tag, " eb_data write"}, eb_row.eb_wdata, eb_data);
            check_eb_data({tag, " eb read back"}, eb_row.eb_wdata, ext_bus_read_data);
        end
        else
        begin
            check_eb_data({tag, " eb_data from device"}, eb_row.eb_rdata, eb_data);
            check_eb_data({tag, " eb read data"}, eb_row.eb_rdata, ext_bus_read_data);
        end
    endtask

    task automatic check_low_phase(input int t);
        stim_row_t reg_row;
        string     tag;
        reg_row = row_at(t - 1);
        tag = $sformatf("cycle %0d", t);
        if (reg_row.dqoe)
        begin
            check_word({tag, " dq write data low"}, reg_row.wr_data, ddr_dram_dq);
            check_mask({tag, " dqs low half"}, reg_row.dqs_low, ddr_dram_dqs);
        end
        else
        begin
            check_word({tag, " captured low"}, reg_row.rd_low, input_dq_low);
            pad_value <= reg_row.rd_high;
        end
        check_bit({tag, " dram clk low"}, 1'b0, ddr_dram_clk);
        check_bit({tag, " dram clk_n low"}, 1'b1, ddr_dram_clk_n);
    endtask

    initial
    begin
        seed = 32'h405d;
        system_reset_in <= 1'b1;
        pad_drive_en <= 1'b0;
        pad_value <= '0;
        drive_row(idle_row());
        fill_table();
        for (int c = 0; c < 10; c++)
        begin
            @(posedge int_drm_clock_buffered);
            #25;
            check_idle_pins($sformatf("reset cycle %0d", c));
        end
        @(posedge int_drm_clock_buffered);
        system_reset_in <= 1'b0;
        #25;
        check_idle_pins("after reset");
        for (int t = 0; t < NUM_ROWS + 2; t++)
        begin
            @(posedge int_drm_clock_buffered);
            drive_row(row_at(t));
            pad_drive_en <= 1'b0;
            #25;
            check_high_phase(t);
            #50;
            check_low_phase(t);
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: ddr_phy_top.sv
/* DDR PHY front end
   command retiming, byte lanes and external bus pins */

`timescale 1ns/1ps

module ddr_phy_top
(
    input  logic                         int_drm_clock_buffered,
    input  logic                         system_reset_in,

    // controller command side
    input  ddr_phy_pkg::ddr_cmd_e        next_cmd,
    input  ddr_phy_pkg::rank_mask_t      next_s_n,
    input  ddr_phy_pkg::bank_t           next_ba,
    input  ddr_phy_pkg::row_addr_t       next_a,
    input  logic                         next_cke,
    input  ddr_phy_pkg::lane_mask_t      next_dqm,

    // controller data side
    input  ddr_phy_pkg::dq_word_t        next_dq,
    input  logic                         next_dqoe,
    input  ddr_phy_pkg::lane_mask_t      next_dqs_high,
    input  ddr_phy_pkg::lane_mask_t      next_dqs_low,
    output wire ddr_phy_pkg::dq_word_t   input_dq_high,
    output wire ddr_phy_pkg::dq_word_t   input_dq_low,

    // DRAM clock pins
    output logic                         ddr_dram_clk,
    output logic                         ddr_dram_clk_n,

    // DRAM command pins
    output wire ddr_phy_pkg::rank_mask_t ddr_dram_cke,
    output wire ddr_phy_pkg::rank_mask_t ddr_dram_s_n,
    output wire                          ddr_dram_ras_n,
    output wire                          ddr_dram_cas_n,
    output wire                          ddr_dram_we_n,
    output wire ddr_phy_pkg::bank_t      ddr_dram_ba,
    output wire ddr_phy_pkg::row_addr_t  ddr_dram_a,
    output wire ddr_phy_pkg::lane_mask_t ddr_dram_dqm,

    // DRAM data pins
    inout  wire ddr_phy_pkg::dq_word_t   ddr_dram_dq,
    inout  wire ddr_phy_pkg::lane_mask_t ddr_dram_dqs,

    // external bus, internal side (active high)
    input  ddr_phy_pkg::eb_ce_t          ext_bus_ce,
    input  logic                         ext_bus_oe,
    input  logic                         ext_bus_we,
    input  ddr_phy_pkg::eb_addr_t        ext_bus_address,
    input  ddr_phy_pkg::eb_data_t        ext_bus_write_data,
    input  logic                         ext_bus_write_data_enable,
    output ddr_phy_pkg::eb_data_t        ext_bus_read_data,

    // external bus pins (active low strobes)
    output ddr_phy_pkg::eb_ce_t          eb_ce_n,
    output logic                         eb_oe_n,
    output logic                         eb_we_n,
    output ddr_phy_pkg::eb_addr_t        eb_address,
    inout  wire ddr_phy_pkg::eb_data_t   eb_data
);

    import ddr_phy_pkg::*;

    // command, address, cke and dqm registers
    ddr_cmd_retime ddr_cmd_retime_i
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .next_cmd               (next_cmd),
        .next_s_n               (next_s_n),
        .next_ba                (next_ba),
        .next_a                 (next_a),
        .next_cke               (next_cke),
        .next_dqm               (next_dqm),
        .ddr_dram_s_n           (ddr_dram_s_n),
        .ddr_dram_ras_n         (ddr_dram_ras_n),
        .ddr_dram_cas_n         (ddr_dram_cas_n),
        .ddr_dram_we_n          (ddr_dram_we_n),
        .ddr_dram_ba            (ddr_dram_ba),
        .ddr_dram_a             (ddr_dram_a),
        .ddr_dram_cke           (ddr_dram_cke),
        .ddr_dram_dqm           (ddr_dram_dqm)
    );

    // one lane per strobe, each takes an eight bit slice of dq
    for (genvar lane = 0; lane < NUM_LANES; lane++)
    begin : g_lane
        ddr_dq_lane ddr_dq_lane_i
        (
            .int_drm_clock_buffered (int_drm_clock_buffered),
            .system_reset_in        (system_reset_in),
            .next_dq                (next_dq[lane*LANE_WIDTH +: LANE_WIDTH]),
            .next_dqoe              (next_dqoe),
            .next_dqs_high          (next_dqs_high[lane]),
            .next_dqs_low           (next_dqs_low[lane]),
            .input_dq_high          (input_dq_high[lane*LANE_WIDTH +: LANE_WIDTH]),
            .input_dq_low           (input_dq_low[lane*LANE_WIDTH +: LANE_WIDTH]),
            .dq_pad                 (ddr_dram_dq[lane*LANE_WIDTH +: LANE_WIDTH]),
            .dqs_pad                (ddr_dram_dqs[lane])
        );
    end

    // differential DRAM clock straight from the internal clock
    assign ddr_dram_clk   = int_drm_clock_buffered;
    assign ddr_dram_clk_n = ~int_drm_clock_buffered;

    // external bus strobes are active low on the board
    assign eb_ce_n    = ~ext_bus_ce;
    assign eb_oe_n    = ~ext_bus_oe;
    assign eb_we_n    = ~ext_bus_we;
    assign eb_address = ext_bus_address;

    // shared data bus, released whenever we are not writing
    assign eb_data           = ext_bus_write_data_enable ? ext_bus_write_data : 'z;
    assign ext_bus_read_data = eb_data;

endmodule

// File: ddr_dq_lane.sv
/* DDR DQ byte lane */

`timescale 1ns/1ps

module ddr_dq_lane
(
    input  logic                    int_drm_clock_buffered,
    input  logic                    system_reset_in,

    // controller side, sampled on the rising edge
    input  ddr_phy_pkg::lane_data_t next_dq,
    input  logic                    next_dqoe,
    input  logic                    next_dqs_high,
    input  logic                    next_dqs_low,

    // captured read data
    output ddr_phy_pkg::lane_data_t input_dq_high,
    output ddr_phy_pkg::lane_data_t input_dq_low,

    // pins
    inout  wire ddr_phy_pkg::lane_data_t dq_pad,
    inout  wire                     dqs_pad
);

    import ddr_phy_pkg::*;

    // outgoing data and strobe halves
    lane_data_t dq_out;
    logic       dqs_high_q;
    logic       dqs_low_q;

    // lane-local enable, shared by the dq pins and the strobe
    logic       oe_q;

    // selected strobe half for the current clock phase
    logic       dqs_level;

    // write data is held steady for the whole cycle (single data rate)
    always_ff @(posedge int_drm_clock_buffered)
    begin
        dq_out     <= next_dq;
        dqs_high_q <= next_dqs_high;
        dqs_low_q  <= next_dqs_low;
    end

    // enable comes up off so the lane never fights the DRAM after reset
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
            oe_q <= 1'b0;
        else
            oe_q <= next_dqoe;
    end

    // high half while the clock is high, low half while it is low
    always_comb
    begin
        if (int_drm_clock_buffered)
            dqs_level = dqs_high_q;
        else
            dqs_level = dqs_low_q;
    end

    assign dq_pad  = oe_q ? dq_out : 'z;
    assign dqs_pad = oe_q ? dqs_level : 1'bz;

    // read capture, rising edge half
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
            input_dq_high <= '0;
        else
            input_dq_high <= dq_pad;
    end

    // read capture on the falling edge, second beat of the burst
    always_ff @(negedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
            input_dq_low <= '0;
        else
            input_dq_low <= dq_pad;
    end

endmodule

// File: ddr_cmd_retime.sv
/* DDR command and address retiming */

`timescale 1ns/1ps

module ddr_cmd_retime
(
    input  logic                    int_drm_clock_buffered,
    input  logic                    system_reset_in,

    input  ddr_phy_pkg::ddr_cmd_e   next_cmd,
    input  ddr_phy_pkg::rank_mask_t next_s_n,
    input  ddr_phy_pkg::bank_t      next_ba,
    input  ddr_phy_pkg::row_addr_t  next_a,
    input  logic                    next_cke,
    input  ddr_phy_pkg::lane_mask_t next_dqm,

    output ddr_phy_pkg::rank_mask_t ddr_dram_s_n,
    output logic                    ddr_dram_ras_n,
    output logic                    ddr_dram_cas_n,
    output logic                    ddr_dram_we_n,
    output ddr_phy_pkg::bank_t      ddr_dram_ba,
    output ddr_phy_pkg::row_addr_t  ddr_dram_a,
    output wire ddr_phy_pkg::rank_mask_t ddr_dram_cke,
    output ddr_phy_pkg::lane_mask_t ddr_dram_dqm
);

    import ddr_phy_pkg::*;

    // first stage, holds the controller's request for one cycle
    ddr_cmd_e   hold_cmd;
    rank_mask_t hold_s_n;
    bank_t      hold_ba;
    row_addr_t  hold_a;

    // hold stage comes out of reset as a deselect so the pins stay idle
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            hold_cmd <= CMD_NOP;
            hold_s_n <= IDLE_S_N;
            hold_ba  <= '0;
            hold_a   <= '0;
        end
        else
        begin
            hold_cmd <= next_cmd;
            hold_s_n <= next_s_n;
            hold_ba  <= next_ba;
            hold_a   <= next_a;
        end
    end

    // output stage, enum split into the three strobe pins
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            ddr_dram_s_n <= IDLE_S_N;
            {ddr_dram_ras_n, ddr_dram_cas_n, ddr_dram_we_n} <= CMD_NOP;
            ddr_dram_ba <= '0;
            ddr_dram_a  <= '0;
        end
        else
        begin
            ddr_dram_s_n <= hold_s_n;
            {ddr_dram_ras_n, ddr_dram_cas_n, ddr_dram_we_n} <= hold_cmd;
            ddr_dram_ba <= hold_ba;
            ddr_dram_a  <= hold_a;
        end
    end

    // one flop per rank so each cke pin gets its own register
    for (genvar rank = 0; rank < NUM_RANKS; rank++)
    begin : g_cke
        logic cke_q;

        always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
        begin
            if (system_reset_in)
                cke_q <= 1'b0;
            else
                cke_q <= next_cke;
        end

        assign ddr_dram_cke[rank] = cke_q;
    end

    // dqm is never tristated, single cycle latency
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
            ddr_dram_dqm <= '0;
        else
            ddr_dram_dqm <= next_dqm;
    end

endmodule

// File: ddr_phy_pkg.sv
/* DDR PHY shared definitions */

package ddr_phy_pkg;

    // data path geometry
    localparam int DQ_WIDTH = 32;
    localparam int LANE_WIDTH = 8;
    localparam int NUM_LANES = DQ_WIDTH / LANE_WIDTH;
    localparam int NUM_RANKS = 2;

    // command and address widths
    localparam int ROW_ADDR_WIDTH = 13;
    localparam int BANK_WIDTH = 2;

    // external bus widths
    localparam int EB_ADDR_WIDTH = 24;
    localparam int EB_DATA_WIDTH = 32;
    localparam int EB_NUM_CE = 4;

    // encoding is {ras_n, cas_n, we_n} as driven on the pins
    typedef enum logic [2:0] {
        CMD_MODE      = 3'b000,
        CMD_REFRESH   = 3'b001,
        CMD_PRECHARGE = 3'b010,
        CMD_ACTIVE    = 3'b011,
        CMD_WRITE     = 3'b100,
        CMD_READ      = 3'b101,
        CMD_TERMINATE = 3'b110,
        CMD_NOP       = 3'b111
    } ddr_cmd_e;

    typedef logic [DQ_WIDTH-1:0] dq_word_t;
    typedef logic [LANE_WIDTH-1:0] lane_data_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [NUM_RANKS-1:0] rank_mask_t;
    typedef logic [ROW_ADDR_WIDTH-1:0] row_addr_t;
    typedef logic [BANK_WIDTH-1:0] bank_t;
    typedef logic [EB_ADDR_WIDTH-1:0] eb_addr_t;
    typedef logic [EB_DATA_WIDTH-1:0] eb_data_t;
    typedef logic [EB_NUM_CE-1:0] eb_ce_t;

    // chip selects are active low, so all ones deselects every rank
    localparam rank_mask_t IDLE_S_N = '1;

endpackage
